// ==== logic/ps2_line_pkg.sv ====
package ps2_line_pkg;

	// ========================================
	// timing constants
	// ========================================

	// system clock rate
	localparam int unsigned CLK_FREQ_HZ = 250_000_000;
	// 5 us debounce window
	localparam int unsigned T_5US_CYCLES = CLK_FREQ_HZ / 200_000;
	// 100 us clock hold before a host transmit
	localparam int unsigned T_100US_CYCLES = CLK_FREQ_HZ / 10_000;
	// one-shot counter width, must cover the 100 us mark
	localparam int unsigned TIMER_W = 16;

	// ========================================
	// line protocol
	// ========================================

	// clock synchronizer length, edges come from the last stage
	localparam int unsigned SYNC_DEPTH = 11;
	// data synchronizer stage that is sampled
	localparam int unsigned DAT_TAP = 2;
	// start, eight data, parity, stop
	localparam int unsigned FRAME_BITS = 11;
	// length of the transmit ring
	localparam int unsigned TX_STEPS = 17;

	// one cycle of synchronized line state
	typedef struct packed {
		logic clk_lvl;
		logic clk_fall;
		logic clk_rise;
		logic dat;
	} ps2_line_t;

	typedef enum logic [1:0] {
		RX_WAIT_CLK = 2'd0,
		RX_CHK_LOW  = 2'd1,
		RX_CAPTURE  = 2'd2
	} rx_state_e;

	// bit positions in the one-hot transmit ring
	typedef enum logic [4:0] {
		TX_PULL_CLK       = 5'd0,
		TX_HOLD_100US     = 5'd1,
		TX_DATA_LOW       = 5'd2,
		TX_WAIT_5US_A     = 5'd3,
		TX_RELEASE_CLK    = 5'd4,
		TX_WAIT_FALL      = 5'd5,
		TX_WAIT_5US_B     = 5'd6,
		TX_SHIFT_WAIT_HI  = 5'd7,
		TX_SHIFT_WAIT_5US = 5'd8,
		TX_STOP_WAIT_HI   = 5'd9,
		TX_STOP_5US       = 5'd10,
		TX_ACK_WAIT_LO    = 5'd11,
		TX_ACK_5US        = 5'd12,
		TX_ACK_SAMPLE     = 5'd13,
		TX_END_WAIT_HI    = 5'd14,
		TX_END_5US        = 5'd15,
		TX_DONE           = 5'd16
	} tx_step_e;

endpackage

// ==== logic/ps2_reg_pkg.sv ====
package ps2_reg_pkg;

	// ========================================
	// register map
	// ========================================

	// register index doubles as the bus opcode
	typedef enum logic [0:0] {
		REG_DATA   = 1'b0,
		REG_STATUS = 1'b1
	} reg_addr_e;

	// status write values
	localparam logic [7:0] CMD_RX_CLEAR = 8'h00;
	localparam logic [7:0] CMD_TX_ABORT = 8'hFF;

	// one host request, valid for a single cycle with cs high
	typedef struct packed {
		logic       cs;
		logic       we;
		reg_addr_e  adr;
		logic [7:0] dat;
	} bus_req_t;

	// status flags gathered for reads
	// read layout puts rx_full in bit 7, tx_done in 6, tx_nack in 5
	// and parity_err in bit 0
	typedef struct packed {
		logic rx_full;
		logic tx_done;
		// inverted keyboard acknowledge
		logic tx_nack;
		logic parity_err;
	} ps2_status_t;

endpackage

// ==== logic/ps2_line_sync.sv ====
`timescale 1ns/1ps

module ps2_line_sync (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    kclk_i,
	input  logic                    kdat_i,
	output ps2_line_pkg::ps2_line_t line_o
);

	import ps2_line_pkg::*;

	// long chain on the clock filters slow edges from the cable
	logic [SYNC_DEPTH-1:0] clk_sync;
	// short chain on data, sampled mid low phase anyway
	logic [DAT_TAP:0] dat_sync;
	// last stage of the clock chain
	logic clk_tap;

	assign clk_tap = clk_sync[SYNC_DEPTH-1];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// idle lines float high
			clk_sync <= '1;
			dat_sync <= '1;
			line_o.clk_lvl <= 1'b1;
			line_o.clk_fall <= 1'b0;
			line_o.clk_rise <= 1'b0;
			line_o.dat <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[SYNC_DEPTH-2:0], kclk_i};
			dat_sync <= {dat_sync[DAT_TAP-1:0], kdat_i};
			// level register doubles as the previous sample
			line_o.clk_lvl <= clk_tap;
			// edge pulses last one cycle
			line_o.clk_fall <= line_o.clk_lvl & ~clk_tap;
			line_o.clk_rise <= ~line_o.clk_lvl & clk_tap;
			line_o.dat <= dat_sync[DAT_TAP];
		end
	end

endmodule

// ==== logic/ps2_timer.sv ====
`timescale 1ns/1ps

module ps2_timer (
	input  logic clk_i,
	input  logic rst_i,
	input  logic clr_i,
	output logic t5_done_o,
	output logic t100_done_o
);

	import ps2_line_pkg::*;

	// one-shot count since the last clear
	logic [TIMER_W-1:0] cnt;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt <= '0;
		end else if (clr_i) begin
			// restart at every debounce or wait start
			cnt <= '0;
		end else if (cnt != '1) begin
			// stop at full scale so no mark repeats
			cnt <= cnt + 1'b1;
		end
	end

	// marks are high only in the cycle the count matches
	assign t5_done_o = (cnt == TIMER_W'(T_5US_CYCLES));
	assign t100_done_o = (cnt == TIMER_W'(T_100US_CYCLES));

endmodule

// ==== logic/ps2_rx_shift.sv ====
`timescale 1ns/1ps

module ps2_rx_shift (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  ps2_line_pkg::ps2_line_t line_i,
	input  logic                    capture_i,
	input  logic                    clear_i,
	output logic [7:0]              byte_o,
	output logic                    rx_full_o,
	output logic                    parity_err_o
);

	import ps2_line_pkg::*;

	// frame register, keyboard sends LSB first
	logic [FRAME_BITS-1:0] frame;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			frame <= '1;
		end else if (clear_i) begin
			// all ones marks an empty frame
			frame <= '1;
		end else if (capture_i) begin
			// new bit enters at the top and walks down
			frame <= {line_i.dat, frame[FRAME_BITS-1:1]};
		end
	end

	// data bits sit between start and parity
	assign byte_o = frame[8:1];

	// start bit is a zero, so it reaching bit 0 means a full frame
	assign rx_full_o = ~frame[0];

	// data plus parity must hold an odd count of ones
	assign parity_err_o = ~^frame[9:1];

endmodule

// ==== logic/ps2_tx_shift.sv ====
`timescale 1ns/1ps

module ps2_tx_shift (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       load_i,
	input  logic [7:0] byte_i,
	input  logic       shift_i,
	input  logic       oe_i,
	output logic       bits_done_o,
	output logic       kdat_en_o
);

	import ps2_line_pkg::*;

	// outgoing frame, bit 0 is on the wire
	logic [FRAME_BITS-1:0] frame;
	// counts down until the stop bit is out
	logic [$clog2(FRAME_BITS+1)-1:0] bit_cnt;

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			// odd parity on top, then the byte
			// a dummy zero under the start bit pulls data low early
			frame <= {~^byte_i, byte_i, 2'b00};
		end else if (shift_i) begin
			// ones fill in behind, so the stop bit is a one
			frame <= {1'b1, frame[FRAME_BITS-1:1]};
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bit_cnt <= '0;
		end else if (load_i) begin
			bit_cnt <= ($clog2(FRAME_BITS+1))'(FRAME_BITS);
		end else if (shift_i && bit_cnt != '0) begin
			bit_cnt <= bit_cnt - 1'b1;
		end
	end

	// stop bit is on the line once the count runs out
	assign bits_done_o = (bit_cnt == '0);

	// open collector, only ever pull low
	assign kdat_en_o = oe_i & ~frame[0];

endmodule

// ==== logic/ps2_regs.sv ====
`timescale 1ns/1ps

module ps2_regs (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  ps2_reg_pkg::bus_req_t    bus_i,
	input  logic [7:0]               byte_i,
	input  ps2_reg_pkg::ps2_status_t status_i,
	output logic [7:0]               dat_o,
	output logic                     tx_load_o,
	output logic [7:0]               tx_byte_o,
	output logic                     rx_clear_o,
	output logic                     tx_abort_o
);

	import ps2_reg_pkg::*;

	// request qualifiers
	logic wr_data;
	logic wr_status;
	logic rd;

	assign wr_data = bus_i.cs & bus_i.we & (bus_i.adr == REG_DATA);
	assign wr_status = bus_i.cs & bus_i.we & (bus_i.adr == REG_STATUS);
	assign rd = bus_i.cs & ~bus_i.we;

	// ========================================
	// write command pulses
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			tx_load_o <= 1'b0;
			rx_clear_o <= 1'b0;
			tx_abort_o <= 1'b0;
		end else begin
			// each pulse lasts one cycle after the request
			tx_load_o <= wr_data;
			rx_clear_o <= wr_status & (bus_i.dat == CMD_RX_CLEAR);
			tx_abort_o <= wr_status & (bus_i.dat == CMD_TX_ABORT);
		end
	end

	// byte to send, valid alongside tx_load_o
	always_ff @(posedge clk_i) begin
		if (wr_data) begin
			tx_byte_o <= bus_i.dat;
		end
	end

	// ========================================
	// registered read mux
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			dat_o <= 8'h00;
		end else if (rd) begin
			case (bus_i.adr)
				REG_DATA:   dat_o <= byte_i;
				REG_STATUS: dat_o <= {status_i.rx_full, status_i.tx_done,
					status_i.tx_nack, 4'b0000, status_i.parity_err};
				default:    dat_o <= 8'h00;
			endcase
		end else begin
			// read data is held for one cycle only
			dat_o <= 8'h00;
		end
	end

endmodule

// ==== logic/ps2_ctrl.sv ====
`timescale 1ns/1ps

module ps2_ctrl (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  ps2_line_pkg::ps2_line_t line_i,
	input  logic                    t5_done_i,
	input  logic                    t100_done_i,
	input  logic                    bits_done_i,
	input  logic                    rx_full_i,
	input  logic                    tx_load_i,
	input  logic                    tx_abort_i,
	output logic                    timer_clr_o,
	output logic                    rx_capture_o,
	output logic                    tx_shift_o,
	output logic                    tx_oe_o,
	output logic                    tx_done_o,
	output logic                    tx_nack_o,
	output logic                    kclk_en_o
);

	import ps2_line_pkg::*;

	rx_state_e rx_state;
	// one-hot transmit sequencer
	logic [TX_STEPS-1:0] tx_ring;
	logic [TX_STEPS-1:0] tx_ring_nxt;
	logic tx_adv;
	// host pulls the clock line
	logic clk_pull;
	// receiver sleeps while a transmit runs
	logic rx_inh;

	assign rx_inh = ~tx_done_o;

	// ========================================
	// receive state machine
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rx_state <= RX_WAIT_CLK;
		end else begin
			case (rx_state)
				// falling clock starts the debounce window
				RX_WAIT_CLK:
					if (line_i.clk_fall && !rx_inh)
						rx_state <= RX_CHK_LOW;
				// still low after 5 us means a real clock
				RX_CHK_LOW:
					if (rx_inh)
						rx_state <= RX_WAIT_CLK;
					else if (t5_done_i)
						rx_state <= line_i.clk_lvl ? RX_WAIT_CLK : RX_CAPTURE;
				RX_CAPTURE:
					rx_state <= RX_WAIT_CLK;
				default:
					rx_state <= RX_WAIT_CLK;
			endcase
		end
	end

	assign rx_capture_o = (rx_state == RX_CAPTURE);

	// ========================================
	// transmit sequencer
	// ========================================

	// advance condition of the active step
	always_comb begin
		case (1'b1)
			tx_ring[TX_PULL_CLK]:       tx_adv = 1'b1;
			tx_ring[TX_HOLD_100US]:     tx_adv = t100_done_i;
			tx_ring[TX_DATA_LOW]:       tx_adv = 1'b1;
			tx_ring[TX_WAIT_5US_A]:     tx_adv = t5_done_i;
			tx_ring[TX_RELEASE_CLK]:    tx_adv = 1'b1;
			tx_ring[TX_WAIT_FALL]:      tx_adv = line_i.clk_fall;
			tx_ring[TX_WAIT_5US_B]:     tx_adv = t5_done_i;
			tx_ring[TX_SHIFT_WAIT_HI]:  tx_adv = line_i.clk_rise;
			tx_ring[TX_SHIFT_WAIT_5US]: tx_adv = t5_done_i;
			tx_ring[TX_STOP_WAIT_HI]:   tx_adv = line_i.clk_rise;
			tx_ring[TX_STOP_5US]:       tx_adv = t5_done_i;
			tx_ring[TX_ACK_WAIT_LO]:    tx_adv = line_i.clk_fall;
			tx_ring[TX_ACK_5US]:        tx_adv = t5_done_i;
			tx_ring[TX_ACK_SAMPLE]:     tx_adv = 1'b1;
			tx_ring[TX_END_WAIT_HI]:    tx_adv = line_i.clk_rise;
			tx_ring[TX_END_5US]:        tx_adv = t5_done_i;
			tx_ring[TX_DONE]:           tx_adv = 1'b0;
			default:                    tx_adv = 1'b0;
		endcase
	end

	// plain rotate except for the bit loop around the shift steps
	always_comb begin
		tx_ring_nxt = {tx_ring[TX_STEPS-2:0], 1'b0};
		tx_ring_nxt[TX_SHIFT_WAIT_HI] = tx_ring[TX_WAIT_5US_B]
			| (tx_ring[TX_SHIFT_WAIT_5US] & ~bits_done_i);
		tx_ring_nxt[TX_STOP_WAIT_HI] = tx_ring[TX_SHIFT_WAIT_5US] & bits_done_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i || tx_abort_i) begin
			tx_ring <= '0;
		end else if (tx_load_i) begin
			tx_ring <= TX_STEPS'(1) << TX_PULL_CLK;
		end else if (tx_ring[TX_DONE]) begin
			tx_ring <= '0;
		end else if (tx_adv) begin
			tx_ring <= tx_ring_nxt;
		end
	end

	// line drives and flags set by individual steps
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			clk_pull <= 1'b0;
			tx_oe_o <= 1'b0;
			tx_done_o <= 1'b1;
			tx_nack_o <= 1'b1;
		end else if (tx_load_i) begin
			tx_done_o <= 1'b0;
		end else if (tx_abort_i) begin
			// drop every drive at once
			clk_pull <= 1'b0;
			tx_oe_o <= 1'b0;
			tx_done_o <= 1'b1;
		end else begin
			if (tx_ring[TX_PULL_CLK])
				clk_pull <= 1'b1;
			// data low doubles as the request to send
			if (tx_ring[TX_DATA_LOW])
				tx_oe_o <= 1'b1;
			// keyboard starts clocking once released
			if (tx_ring[TX_RELEASE_CLK])
				clk_pull <= 1'b0;
			if (tx_ring[TX_STOP_WAIT_HI])
				tx_oe_o <= 1'b0;
			// keyboard pulls data low to acknowledge
			if (tx_ring[TX_ACK_SAMPLE])
				tx_nack_o <= line_i.dat;
			if (tx_ring[TX_DONE])
				tx_done_o <= 1'b1;
		end
	end

	// next bit goes out on each rising clock
	// the release step also moves the start bit under data
	assign tx_shift_o = (tx_ring[TX_SHIFT_WAIT_HI] & line_i.clk_rise)
		| tx_ring[TX_RELEASE_CLK];

	// restart the one-shot wherever a wait is about to begin
	assign timer_clr_o = (rx_state == RX_WAIT_CLK && line_i.clk_fall && !rx_inh)
		|| (rx_state == RX_CHK_LOW && rx_inh)
		|| tx_ring[TX_PULL_CLK] || tx_ring[TX_DATA_LOW]
		|| tx_ring[TX_WAIT_FALL] || tx_ring[TX_SHIFT_WAIT_HI]
		|| tx_ring[TX_STOP_WAIT_HI] || tx_ring[TX_ACK_WAIT_LO]
		|| tx_ring[TX_END_WAIT_HI];

	// an unread byte holds the keyboard off
	assign kclk_en_o = clk_pull | rx_full_i;

endmodule

// ==== logic/ps2_kbd_top.sv ====
`timescale 1ns/1ps

module ps2_kbd_top (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  ps2_reg_pkg::bus_req_t bus_i,
	output logic [7:0]            dat_o,
	output logic                  irq_o,
	input  logic                  kclk_i,
	input  logic                  kdat_i,
	output logic                  kclk_en_o,
	output logic                  kdat_en_o
);

	import ps2_line_pkg::*;
	import ps2_reg_pkg::*;

	ps2_line_t line;
	ps2_status_t status;
	logic timer_clr, t5_done, t100_done;
	logic rx_capture, rx_clear, rx_full, parity_err;
	logic [7:0] rx_byte;
	logic tx_load, tx_abort, tx_shift, tx_oe, bits_done;
	logic tx_done, tx_nack;
	logic [7:0] tx_byte;

	// interrupt level follows the receive full flag
	assign irq_o = rx_full;
	assign status = '{rx_full: rx_full, tx_done: tx_done,
		tx_nack: tx_nack, parity_err: parity_err};

	ps2_line_sync u_sync (.clk_i, .rst_i, .kclk_i, .kdat_i, .line_o(line));

	ps2_timer u_timer (.clk_i, .rst_i, .clr_i(timer_clr),
		.t5_done_o(t5_done), .t100_done_o(t100_done));

	ps2_rx_shift u_rx (.clk_i, .rst_i, .line_i(line), .capture_i(rx_capture),
		.clear_i(rx_clear), .byte_o(rx_byte), .rx_full_o(rx_full),
		.parity_err_o(parity_err));

	ps2_tx_shift u_tx (.clk_i, .rst_i, .load_i(tx_load), .byte_i(tx_byte),
		.shift_i(tx_shift), .oe_i(tx_oe), .bits_done_o(bits_done),
		.kdat_en_o(kdat_en_o));

	ps2_regs u_regs (.clk_i, .rst_i, .bus_i, .byte_i(rx_byte), .status_i(status),
		.dat_o(dat_o), .tx_load_o(tx_load), .tx_byte_o(tx_byte),
		.rx_clear_o(rx_clear), .tx_abort_o(tx_abort));

	// controller sits between the line, the timer and both shifters
	ps2_ctrl u_ctrl (.clk_i, .rst_i, .line_i(line), .t5_done_i(t5_done),
		.t100_done_i(t100_done), .bits_done_i(bits_done), .rx_full_i(rx_full),
		.tx_load_i(tx_load), .tx_abort_i(tx_abort), .timer_clr_o(timer_clr),
		.rx_capture_o(rx_capture), .tx_shift_o(tx_shift), .tx_oe_o(tx_oe),
		.tx_done_o(tx_done), .tx_nack_o(tx_nack), .kclk_en_o(kclk_en_o));

endmodule

// ==== dv/ps2_kbd_tb.sv ====
`timescale 1ns/1ps

module ps2_kbd_tb;

	import ps2_reg_pkg::*;

	// ========================================
	// bench timing
	// ========================================

	localparam int CLK_NS = 4;
	// system clocks in one microsecond
	localparam int CYC_PER_US = 1000 / CLK_NS;
	// keyboard clock half period in us
	localparam int HALF_US = 40;
	// shortest legal clock hold before a host transmit
	localparam int HOLD_MIN_CYC = 100 * CYC_PER_US;
	localparam int NUM_TESTS = 6;
	// host transmit is the longest frame, 100 us hold plus twelve keyboard clocks
	localparam longint FRAME_NS = 1_200_000;
	localparam longint WATCHDOG_NS = NUM_TESTS * FRAME_NS + 1_000_000;

	logic clk = 1'b0;
	logic rst;
	bus_req_t bus;
	logic [7:0] dat;
	logic irq;
	// keyboard side of the lines
	logic kclk;
	logic kdat;
	logic kclk_en;
	logic kdat_en;

	int val_errors;
	int other_errors;

	ps2_kbd_top dut0 (
		.clk_i(clk),
		.rst_i(rst),
		.bus_i(bus),
		.dat_o(dat),
		.irq_o(irq),
		.kclk_i(kclk),
		.kdat_i(kdat),
		.kclk_en_o(kclk_en),
		.kdat_en_o(kdat_en)
	);

	initial begin
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// hard stop if a handshake never arrives
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the tests did not finish", $time);
		$display("STATUS: FAIL");
		$finish;
	end

	// ========================================
	// checking helpers
	// ========================================

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			val_errors++;
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic step_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic delay_us(input int us);
		step_cycles(us * CYC_PER_US);
	endtask

	// ========================================
	// register port
	// ========================================

	task automatic write_reg(input reg_addr_e adr, input logic [7:0] d);
		@(negedge clk);
		bus.cs = 1'b1;
		bus.we = 1'b1;
		bus.adr = adr;
		bus.dat = d;
		@(negedge clk);
		bus = '0;
	endtask

	// read data shows one cycle after the request, then drops to zero
	task automatic read_reg(input reg_addr_e adr, output logic [7:0] d);
		@(negedge clk);
		bus.cs = 1'b1;
		bus.we = 1'b0;
		bus.adr = adr;
		bus.dat = 8'h00;
		@(negedge clk);
		bus = '0;
		d = dat;
		@(negedge clk);
		compare_value("dat_o after read", dat, 16'h0000);
	endtask

	// ========================================
	// keyboard line model
	// ========================================

	// device to host, data changes mid high phase
	task automatic drive_frame(input logic [7:0] b, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, ~^b ^ bad_parity, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			kdat = frame[i];
			delay_us(HALF_US / 2);
			kclk = 1'b0;
			delay_us(HALF_US);
			kclk = 1'b1;
			delay_us(HALF_US / 2);
		end
		kdat = 1'b1;
	endtask

	task automatic await_clock_pull(input logic level, input int max_cyc, output int cyc);
		cyc = 0;
		while (kclk_en !== level && cyc < max_cyc) begin
			@(negedge clk);
			cyc++;
		end
		assert (kclk_en === level) else
			report_failure($sformatf("kclk_en_o did not reach %0b in %0d cycles", level, max_cyc));
	endtask

	task automatic await_irq(input int max_cyc);
		int n;
		n = 0;
		while (irq !== 1'b1 && n < max_cyc) begin
			@(negedge clk);
			n++;
		end
		assert (irq === 1'b1) else report_failure("irq_o did not rise after a full frame");
	endtask

	// host to device, bits sampled mid low phase, then an acknowledge clock
	task automatic accept_host_frame(output logic [10:0] bits, output int hold_cyc);
		int n;
		await_clock_pull(1'b1, 100, n);
		await_clock_pull(1'b0, 2 * HOLD_MIN_CYC, hold_cyc);
		compare_value("kdat_en_o at clock release", kdat_en, 16'h0001);
		delay_us(HALF_US / 2);
		for (int i = 0; i < 11; i++) begin
			kclk = 1'b0;
			delay_us(HALF_US / 2);
			// a pulled data line reads as zero
			bits[i] = ~kdat_en;
			delay_us(HALF_US / 2);
			kclk = 1'b1;
			delay_us(HALF_US);
		end
		kdat = 1'b0;
		delay_us(HALF_US / 2);
		kclk = 1'b0;
		delay_us(HALF_US);
		kclk = 1'b1;
		delay_us(HALF_US / 2);
		kdat = 1'b1;
	endtask

	task automatic poll_tx_done(input int max_reads);
		logic [7:0] st;
		int n;
		n = 0;
		st = 8'h00;
		while (!st[6] && n < max_reads) begin
			read_reg(REG_STATUS, st);
			n++;
		end
		assert (st[6] === 1'b1) else report_failure("tx_done never came back after a transmit");
	endtask

	// ========================================
	// directed tests
	// ========================================

	task automatic receive_good_frame();
		logic [7:0] b;
		logic [7:0] rd;
		b = 8'($urandom);
		drive_frame(b, 1'b0);
		await_irq(100 * CYC_PER_US);
		compare_value("irq_o", irq, 16'h0001);
		// unread byte holds the keyboard off
		compare_value("kclk_en_o", kclk_en, 16'h0001);
		read_reg(REG_DATA, rd);
		compare_value("rx byte", rd, b);
		read_reg(REG_STATUS, rd);
		compare_value("status rx_full", rd[7], 16'h0001);
		compare_value("status parity_err", rd[0], 16'h0000);
	endtask

	task automatic clear_receiver();
		logic [7:0] rd;
		write_reg(REG_STATUS, CMD_RX_CLEAR);
		step_cycles(1);
		compare_value("irq_o after clear", irq, 16'h0000);
		compare_value("kclk_en_o after clear", kclk_en, 16'h0000);
		read_reg(REG_STATUS, rd);
		compare_value("status rx_full after clear", rd[7], 16'h0000);
	endtask

	task automatic receive_bad_parity();
		logic [7:0] b;
		logic [7:0] rd;
		b = 8'($urandom);
		drive_frame(b, 1'b1);
		await_irq(100 * CYC_PER_US);
		read_reg(REG_STATUS, rd);
		compare_value("status rx_full", rd[7], 16'h0001);
		compare_value("status parity_err", rd[0], 16'h0001);
		clear_receiver();
	endtask

	task automatic transmit_byte();
		logic [7:0] b;
		logic [7:0] rd;
		logic [10:0] bits;
		int hold;
		b = 8'($urandom);
		write_reg(REG_DATA, b);
		accept_host_frame(bits, hold);
		assert (hold >= HOLD_MIN_CYC) else begin
			val_errors++;
			$display("FAILED at %0t: kclk_en_o hold is %0d cycles, expected at least %0d",
				$time, hold, HOLD_MIN_CYC);
		end
		compare_value("tx start bit", bits[0], 16'h0000);
		compare_value("tx data byte", bits[8:1], b);
		compare_value("tx parity bit", bits[9], ~^b);
		compare_value("tx stop bit", bits[10], 16'h0001);
		poll_tx_done(2000);
		read_reg(REG_STATUS, rd);
		compare_value("status tx_done", rd[6], 16'h0001);
		compare_value("status tx_nack", rd[5], 16'h0000);
	endtask

	task automatic abort_transmit();
		logic [7:0] rd;
		int n;
		write_reg(REG_DATA, 8'($urandom));
		await_clock_pull(1'b1, 100, n);
		// land inside the 100 us hold
		delay_us(20);
		write_reg(REG_STATUS, CMD_TX_ABORT);
		step_cycles(1);
		compare_value("kclk_en_o after abort", kclk_en, 16'h0000);
		read_reg(REG_STATUS, rd);
		compare_value("status tx_done after abort", rd[6], 16'h0001);
		// a stopped sequencer never reaches the data low step
		delay_us(100);
		compare_value("kclk_en_o after the hold time", kclk_en, 16'h0000);
		compare_value("kdat_en_o after the hold time", kdat_en, 16'h0000);
	endtask

	// 2 us pulses, spaced wider than the debounce window
	task automatic reject_glitches();
		kdat = 1'b0;
		for (int i = 0; i < 12; i++) begin
			kclk = 1'b0;
			delay_us(2);
			kclk = 1'b1;
			delay_us(10);
			compare_value("irq_o during glitches", irq, 16'h0000);
		end
		kdat = 1'b1;
		compare_value("kclk_en_o after glitches", kclk_en, 16'h0000);
	endtask

	// ========================================
	// run
	// ========================================

	initial begin
		logic [7:0] rd;
		void'($urandom(48));
		rst = 1'b1;
		bus = '0;
		kclk = 1'b1;
		kdat = 1'b1;
		val_errors = 0;
		other_errors = 0;
		step_cycles(3);
		rst = 1'b0;
		step_cycles(2);
		compare_value("kclk_en_o after reset", kclk_en, 16'h0000);
		compare_value("kdat_en_o after reset", kdat_en, 16'h0000);
		compare_value("irq_o after reset", irq, 16'h0000);
		compare_value("dat_o after reset", dat, 16'h0000);
		// tx_done and tx_nack both come up set
		read_reg(REG_STATUS, rd);
		compare_value("status after reset", rd, 16'h0060);
		receive_good_frame();
		clear_receiver();
		receive_bad_parity();
		transmit_byte();
		abort_transmit();
		reject_glitches();
		step_cycles(10);
		$display("errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
		if (val_errors == 0 && other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== build.f ====
logic/ps2_line_pkg.sv
logic/ps2_reg_pkg.sv
logic/ps2_line_sync.sv
logic/ps2_timer.sv
logic/ps2_rx_shift.sv
logic/ps2_tx_shift.sv
logic/ps2_regs.sv
logic/ps2_ctrl.sv
logic/ps2_kbd_top.sv
dv/ps2_kbd_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the PS/2 host testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module ps2_kbd_tb -o ps2_kbd_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/ps2_kbd_sim)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
	echo "simulation exited with status $rc"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
